/* design/idx_pkg.sv */
// widths and types of the indexed address unit
// full-register codes, register select helpers and step decoding
// addressing-mode decoder state
package idx_pkg;

    typedef logic [23:0] addr_t;        // memory address
    typedef logic [31:0] reg_t;         // general register value
    typedef logic [2:0]  reg_code_t;    // full register code
    typedef logic [7:0]  byte_sel_t;    // {bank, reg, byte} select
    typedef logic [31:0] op_win_t;      // first byte in [7:0]
    typedef logic [2:0]  fetch_t;       // bytes consumed per cycle
    typedef logic [1:0]  step_t;        // 0:1, 1:2, 2:4
    typedef logic [1:0]  offset_sel_t;

    typedef enum logic [1:0] {st_idle, st_ext, st_add, st_done} mode_state_t;

    localparam offset_sel_t off_disp  = 2'd0;   // latched displacement
    localparam offset_sel_t off_idx8  = 2'd1;   // signed 8-bit register index
    localparam offset_sel_t off_idx16 = 2'd2;   // signed 16-bit register index

    localparam reg_code_t code_xwa = 3'd0;
    localparam reg_code_t code_xbc = 3'd1;
    localparam reg_code_t code_xde = 3'd2;
    localparam reg_code_t code_xhl = 3'd3;
    localparam reg_code_t code_xix = 3'd4;
    localparam reg_code_t code_xiy = 3'd5;
    localparam reg_code_t code_xiz = 3'd6;
    localparam reg_code_t code_xsp = 3'd7;

    localparam logic [2:0] cur_bank = 3'b111;   // selects e0..ff
    localparam byte_sel_t  null_sel = 8'h40;    // reads back as zero

    function automatic byte_sel_t full_sel(input reg_code_t code);
        full_sel = {cur_bank, code, 2'b00};
    endfunction

    function automatic reg_t step_size(input step_t s);
        case (s)
            2'd0:    step_size = 32'd1;
            2'd1:    step_size = 32'd2;
            2'd2:    step_size = 32'd4;
            default: step_size = 32'd0;
        endcase
    endfunction

    function automatic addr_t sext8(input logic [7:0] v);
        sext8 = {{16{v[7]}}, v};
    endfunction

    function automatic addr_t sext16(input logic [15:0] v);
        sext16 = {{8{v[15]}}, v};
    endfunction

endpackage

/* design/idx_mode_fsm.sv */
// addressing-mode byte decoder
// phase state machine: decode, optional extension bytes, address add
`timescale 1ns/100ps

module idx_mode_fsm import idx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  op_win_t     op,
    output logic        busy,
    output fetch_t      fetched,
    output byte_sel_t   rd_sel,
    output byte_sel_t   aux_sel,
    output addr_t       disp,
    output offset_sel_t offset_sel,
    output step_t       step,
    output logic        pre_dec,
    output logic        post_inc,
    output logic        calc_en
);

    mode_state_t state, state_nx;
    logic [4:0]  mode;
    byte_sel_t   rd_sel_nx;
    byte_sel_t   aux_sel_nx;
    addr_t       disp_nx;
    offset_sel_t offset_sel_nx;
    step_t       step_nx;
    logic        pre_dec_nx;
    logic        post_inc_nx;

    assign mode    = {op[6], op[3:0]};          // mode byte fields that matter
    assign busy    = (state == st_ext) || (state == st_add);
    assign calc_en = (state == st_add);

    always_comb begin
        state_nx      = state;
        fetched       = '0;
        rd_sel_nx     = rd_sel;
        aux_sel_nx    = aux_sel;
        disp_nx       = disp;
        offset_sel_nx = offset_sel;
        step_nx       = step;
        pre_dec_nx    = pre_dec;
        post_inc_nx   = post_inc;
        case (state)
            st_idle, st_done: begin
                state_nx = st_idle;
                if (start) begin
                    pre_dec_nx    = 1'b0;
                    post_inc_nx   = 1'b0;
                    offset_sel_nx = off_disp;
                    casez (mode)
                        5'b0????: begin                     // (r32) or (r32+d8)
                            rd_sel_nx = full_sel(op[2:0]);
                            disp_nx   = op[3] ? sext8(op[15:8]) : '0;
                            fetched   = op[3] ? 3'd2 : 3'd1;
                            state_nx  = st_add;
                        end
                        5'h10, 5'h11, 5'h12: begin          // absolute address
                            rd_sel_nx = null_sel;
                            state_nx  = st_add;
                            case (op[1:0])
                                2'd0: begin
                                    disp_nx = {16'd0, op[15:8]};
                                    fetched = 3'd2;
                                end
                                2'd1: begin
                                    disp_nx = {8'd0, op[23:8]};
                                    fetched = 3'd3;
                                end
                                default: begin
                                    disp_nx = op[31:8];
                                    fetched = 3'd4;
                                end
                            endcase
                        end
                        5'h13: begin
                            rd_sel_nx = {op[15:10], 2'b00};
                            disp_nx   = '0;
                            case (op[9:8])
                                2'd0: begin                 // (r32), long form
                                    fetched  = 3'd2;
                                    state_nx = st_add;
                                end
                                2'd1: begin                 // (r32+d16)
                                    fetched  = 3'd2;
                                    state_nx = st_ext;
                                end
                                2'd3: begin                 // (r32+r8) or (r32+r16)
                                    offset_sel_nx = op[10] ? off_idx16 : off_idx8;
                                    fetched       = 3'd2;
                                    state_nx      = st_ext;
                                end
                                default: state_nx = st_idle;  // not decoded
                            endcase
                        end
                        5'h14, 5'h15: begin                 // (-r32) or (r32+)
                            rd_sel_nx   = {op[15:10], 2'b00};
                            disp_nx     = '0;
                            step_nx     = op[9:8];
                            pre_dec_nx  = ~op[0];
                            post_inc_nx = op[0];
                            fetched     = 3'd2;
                            state_nx    = st_add;
                        end
                        default: state_nx = st_idle;
                    endcase
                end
            end
            st_ext: begin
                // window now starts at the bytes after the register byte
                fetched  = 3'd2;
                state_nx = st_add;
                if (offset_sel == off_disp) begin
                    disp_nx = sext16(op[15:0]);
                end else begin
                    rd_sel_nx  = op[7:0];               // base register
                    aux_sel_nx = op[15:8];              // index register
                end
            end
            st_add: begin
                state_nx    = st_done;
                pre_dec_nx  = 1'b0;                     // update taken this edge
                post_inc_nx = 1'b0;
            end
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            offset_sel <= off_disp;
            step       <= '0;
            pre_dec    <= 1'b0;
            post_inc   <= 1'b0;
        end else begin
            state      <= state_nx;
            offset_sel <= offset_sel_nx;
            step       <= step_nx;
            pre_dec    <= pre_dec_nx;
            post_inc   <= post_inc_nx;
        end
    end

    always_ff @(posedge clk) begin
        rd_sel  <= rd_sel_nx;
        aux_sel <= aux_sel_nx;
        disp    <= disp_nx;
    end

endmodule

/* design/idx_pc_counter.sv */
// program-counter accumulator
// advances by the bytes the decoder consumes each cycle
`timescale 1ns/100ps

module idx_pc_counter import idx_pkg::*; #(
    parameter addr_t pc_reset = 24'h000000
) (
    input  logic   clk,
    input  logic   rst,
    input  fetch_t fetched,
    output addr_t  pc
);

    addr_t pc_nx;

    assign pc_nx = pc + addr_t'(fetched);       // wraps at 24 bits

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= pc_reset;
        end else if (fetched != '0) begin
            pc <= pc_nx;
        end
    end

endmodule

/* design/idx_reg_bank.sv */
// general register file, eight 32-bit registers
// load port, full and byte/halfword read ports, step write-back
`timescale 1ns/100ps

module idx_reg_bank import idx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  reg_code_t   wr_code,
    input  reg_t        wr_data,
    input  byte_sel_t   rd_sel,
    input  byte_sel_t   aux_sel,
    input  logic        pre_dec,
    input  logic        post_inc,
    input  step_t       step,
    input  logic        upd,
    output reg_t        rd_data,
    output logic [15:0] aux_data
);

    reg_t regs [8];
    reg_t rd_word;
    reg_t aux_word;
    reg_t upd_value;
    logic rd_cur;
    logic aux_cur;

    // only the current bank is modelled, any other select reads zero
    assign rd_cur  = (rd_sel[7:5] == cur_bank);
    assign aux_cur = (aux_sel[7:5] == cur_bank);

    assign rd_word  = regs[rd_sel[4:2]];
    assign aux_word = regs[aux_sel[4:2]] >> {aux_sel[1:0], 3'b000};   // byte aligned

    assign rd_data  = rd_cur ? rd_word : '0;
    assign aux_data = aux_cur ? aux_word[15:0] : '0;

    always_comb begin
        if (pre_dec) begin
            upd_value = rd_word - step_size(step);
        end else begin
            upd_value = rd_word + step_size(step);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_code] <= wr_data;             // load wins over write-back
        end else if (upd && (pre_dec || post_inc)) begin
            regs[rd_sel[4:2]] <= upd_value;
        end
    end

endmodule

/* design/idx_addr_calc.sv */
// effective-address adder
// base register, pre-decrement offset, displacement or signed index
`timescale 1ns/100ps

module idx_addr_calc import idx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        calc_en,
    input  reg_t        rd_data,
    input  logic [15:0] aux_data,
    input  addr_t       disp,
    input  offset_sel_t offset_sel,
    input  logic        pre_dec,
    input  step_t       step,
    output addr_t       addr,
    output logic        addr_valid,
    output logic        upd
);

    addr_t base;
    addr_t offset;
    addr_t sum;

    always_comb begin
        base = rd_data[23:0];
        if (pre_dec) begin
            base = base - addr_t'(step_size(step));   // -r32 points below
        end
    end

    always_comb begin
        case (offset_sel)
            off_idx8:  offset = sext8(aux_data[7:0]);
            off_idx16: offset = sext16(aux_data);
            default:   offset = disp;
        endcase
    end

    assign sum = base + offset;

    // register write-back lands on the same edge as the address
    assign upd = calc_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= calc_en;
        end
    end

    always_ff @(posedge clk) begin
        if (calc_en) begin
            addr <= sum;
        end
    end

endmodule

/* design/idx_addr_top.sv */
// indexed memory-address unit, top level
// mode decoder, register bank, address adder and pc counter
`timescale 1ns/100ps

module idx_addr_top import idx_pkg::*; #(
    parameter addr_t pc_reset = 24'h000000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  op_win_t   op,
    input  logic      wr_en,
    input  reg_code_t wr_code,
    input  reg_t      wr_data,
    output logic      busy,
    output fetch_t    fetched,
    output logic      addr_valid,
    output addr_t     addr,
    output addr_t     pc
);

    byte_sel_t   rd_sel;
    byte_sel_t   aux_sel;
    addr_t       disp;
    offset_sel_t offset_sel;
    step_t       step;
    logic        pre_dec;
    logic        post_inc;
    logic        calc_en;
    logic        upd;
    reg_t        rd_data;
    logic [15:0] aux_data;

    idx_mode_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .busy       (busy),
        .fetched    (fetched),
        .rd_sel     (rd_sel),
        .aux_sel    (aux_sel),
        .disp       (disp),
        .offset_sel (offset_sel),
        .step       (step),
        .pre_dec    (pre_dec),
        .post_inc   (post_inc),
        .calc_en    (calc_en)
    );

    idx_pc_counter #(.pc_reset(pc_reset)) u_pc (
        .clk     (clk),
        .rst     (rst),
        .fetched (fetched),
        .pc      (pc)
    );

    idx_reg_bank u_bank (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_code  (wr_code),
        .wr_data  (wr_data),
        .rd_sel   (rd_sel),
        .aux_sel  (aux_sel),
        .pre_dec  (pre_dec),
        .post_inc (post_inc),
        .step     (step),
        .upd      (upd),
        .rd_data  (rd_data),
        .aux_data (aux_data)
    );

    idx_addr_calc u_calc (
        .clk        (clk),
        .rst        (rst),
        .calc_en    (calc_en),
        .rd_data    (rd_data),
        .aux_data   (aux_data),
        .disp       (disp),
        .offset_sel (offset_sel),
        .pre_dec    (pre_dec),
        .step       (step),
        .addr       (addr),
        .addr_valid (addr_valid),
        .upd        (upd)
    );

endmodule

/* sim/idx_addr_props.sv */
// decoder timing assertions, bound to the mode FSM
`timescale 1ns/100ps

module idx_addr_props import idx_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   start,
    input logic   busy,
    input fetch_t fetched,
    input logic   calc_en
);

    // add phase is one cycle, so addr_valid is a single pulse
    calc_one_cycle: assert property (@(posedge clk) disable iff (rst)
        calc_en |=> !calc_en)
        else $error("calc_en held for more than one cycle");

    // accepted start reaches the adder after one or two cycles
    start_to_calc: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |=> ##[0:1] calc_en)
        else $error("no address add within two cycles of an accepted start");

    // bytes are taken only at decode and in the extension phase
    fetch_in_phase: assert property (@(posedge clk) disable iff (rst)
        (fetched != '0) |-> ((start && !busy) || (busy && !calc_en)))
        else $error("operand bytes consumed outside decode or extension");

endmodule

/* sim/idx_addr_tb.sv */
// testbench for the indexed address unit
// stimulus table, operand byte window and reference address model
`timescale 1ns/100ps

module idx_addr_tb import idx_pkg::*; ();

    localparam addr_t pc_start    = 24'hFF_FFF0;   // pc wraps during the run
    localparam int    rst_cycles  = 5;
    localparam int    max_entries = 32;
    localparam int    k_abs       = 0;
    localparam int    k_reg       = 1;              // base plus signed disp
    localparam int    k_idx8      = 2;
    localparam int    k_idx16     = 3;
    localparam int    k_pre       = 4;
    localparam int    k_post      = 5;

    logic      clk;
    logic      rst;
    logic      start;
    op_win_t   op;
    logic      wr_en;
    reg_code_t wr_code;
    reg_t      wr_data;
    logic      busy;
    fetch_t    fetched;
    logic      addr_valid;
    addr_t     addr;
    addr_t     pc;

    logic [31:0] t_bytes [max_entries];             // instruction bytes, first in [7:0]
    int          t_len   [max_entries];
    int          t_lat   [max_entries];
    int          t_kind  [max_entries];
    reg_code_t   t_base  [max_entries];
    logic [23:0] t_lit   [max_entries];             // absolute address or displacement
    int          t_lit_w [max_entries];
    reg_code_t   t_ix    [max_entries];
    logic [1:0]  t_ix_b  [max_entries];
    logic [1:0]  t_step  [max_entries];
    logic        t_again [max_entries];             // second start while busy
    int          n_entries;

    reg_t        ref_regs [8];
    logic [7:0]  win_q [$];
    addr_t       pc_exp;
    int          errors;
    int          checks;
    int          cycle_cnt;
    int          cycle_limit;

    idx_addr_top #(.pc_reset(pc_start)) uut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .wr_en      (wr_en),
        .wr_code    (wr_code),
        .wr_data    (wr_data),
        .busy       (busy),
        .fetched    (fetched),
        .addr_valid (addr_valid),
        .addr       (addr),
        .pc         (pc)
    );

    bind idx_mode_fsm idx_addr_props u_props (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .busy    (busy),
        .fetched (fetched),
        .calc_en (calc_en)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: no end of test after %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [7:0] reg_byte(input reg_code_t code, input logic [1:0] low);
        reg_byte = {3'b111, code, low};             // current bank select byte
    endfunction

    function automatic op_win_t window();
        op_win_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = (b < win_q.size()) ? win_q[b] : 8'h00;
        end
        return w;
    endfunction

    task automatic push_entry(input logic [31:0] bytes, input int len, input int lat,
                              input int kind, input reg_code_t base,
                              input logic [23:0] lit, input int lit_w);
        t_bytes[n_entries] = bytes;
        t_len[n_entries]   = len;
        t_lat[n_entries]   = lat;
        t_kind[n_entries]  = kind;
        t_base[n_entries]  = base;
        t_lit[n_entries]   = lit;
        t_lit_w[n_entries] = lit_w;
        t_ix[n_entries]    = '0;
        t_ix_b[n_entries]  = '0;
        t_step[n_entries]  = '0;
        t_again[n_entries] = 1'b0;
        n_entries++;
    endtask

    task automatic add_abs(input int width, input logic [23:0] v);
        case (width)
            1: push_entry({16'h0, v[7:0], 8'hC0}, 2, 2, k_abs, '0, {16'h0, v[7:0]}, 1);
            2: push_entry({8'h0, v[15:0], 8'hC1}, 3, 2, k_abs, '0, {8'h0, v[15:0]}, 2);
            default: push_entry({v, 8'hC2}, 4, 2, k_abs, '0, v, 3);
        endcase
    endtask

    task automatic add_reg(input reg_code_t code, input int d_w, input logic [23:0] d);
        case (d_w)
            0: push_entry({24'h0, 5'b10000, code}, 1, 2, k_reg, code, '0, 0);
            1: push_entry({16'h0, d[7:0], 5'b10001, code}, 2, 2, k_reg, code, d, 1);
            default: push_entry({d[15:0], reg_byte(code, 2'b01), 8'hC3}, 4, 3,
                                k_reg, code, d, 2);
        endcase
    endtask

    task automatic add_idx(input reg_code_t base, input reg_code_t ix,
                           input logic [1:0] ix_b, input logic wide);
        push_entry({reg_byte(ix, ix_b), reg_byte(base, 2'b00), wide ? 8'h07 : 8'h03, 8'hC3},
                   4, 3, wide ? k_idx16 : k_idx8, base, '0, 0);
        t_ix[n_entries - 1]   = ix;
        t_ix_b[n_entries - 1] = ix_b;
    endtask

    task automatic add_step(input reg_code_t code, input logic [1:0] step, input logic post);
        push_entry({16'h0, reg_byte(code, step), post ? 8'hC5 : 8'hC4}, 2, 2,
                   post ? k_post : k_pre, code, '0, 0);
        t_step[n_entries - 1] = step;
    endtask

    task automatic build_table();
        add_abs(1, 24'h00005A);
        add_abs(2, 24'h008123);
        add_abs(3, 24'hFEDCBA);
        add_reg(code_xwa, 0, '0);
        add_reg(code_xbc, 1, 24'h000012);
        add_reg(code_xde, 1, 24'h00009C);           // negative d8
        add_reg(code_xhl, 2, 24'h001234);
        add_reg(code_xix, 2, 24'h008010);           // negative d16
        add_reg(code_xsp, 1, 24'h000080);
        add_idx(code_xiy, code_xwa, 2'd1, 1'b0);
        add_idx(code_xsp, code_xbc, 2'd3, 1'b0);
        add_idx(code_xde, code_xiz, 2'd0, 1'b1);
        add_idx(code_xwa, code_xhl, 2'd2, 1'b1);
        add_step(code_xix, 2'd2, 1'b0);
        add_reg(code_xix, 0, '0);                   // sees the decremented register
        add_step(code_xiy, 2'd0, 1'b1);
        add_reg(code_xiy, 0, '0);
        add_step(code_xbc, 2'd1, 1'b0);
        add_reg(code_xbc, 1, 24'h0000F0);
        add_step(code_xde, 2'd1, 1'b1);
        add_step(code_xsp, 2'd2, 1'b1);
        add_reg(code_xsp, 0, '0);
        add_step(code_xhl, 2'd0, 1'b0);
        add_reg(code_xhl, 0, '0);
        add_reg(code_xwa, 2, 24'h00FFFF);
        t_again[n_entries - 1] = 1'b1;
        add_abs(1, 24'h0000A5);
    endtask

    // reference address, also applies the register step of -r32 and r32+
    task automatic expect_addr(input int i, output addr_t exp);
        reg_t base;
        reg_t ix_word;
        reg_t step_val;
        base     = ref_regs[t_base[i]];
        ix_word  = ref_regs[t_ix[i]] >> (8 * t_ix_b[i]);
        step_val = 32'd1 << t_step[i];
        case (t_kind[i])
            k_abs: exp = t_lit[i];
            k_reg: begin
                if (t_lit_w[i] == 1) begin
                    exp = base[23:0] + {{16{t_lit[i][7]}}, t_lit[i][7:0]};
                end else if (t_lit_w[i] == 2) begin
                    exp = base[23:0] + {{8{t_lit[i][15]}}, t_lit[i][15:0]};
                end else begin
                    exp = base[23:0];
                end
            end
            k_idx8:  exp = base[23:0] + {{16{ix_word[7]}}, ix_word[7:0]};
            k_idx16: exp = base[23:0] + {{8{ix_word[15]}}, ix_word[15:0]};
            k_pre: begin
                ref_regs[t_base[i]] = base - step_val;
                exp = base[23:0] - step_val[23:0];
            end
            default: begin
                ref_regs[t_base[i]] = base + step_val;
                exp = base[23:0];
            end
        endcase
    endtask

    task automatic check_idle();
        check("busy", busy, 1'b0);
        check("fetched", fetched, '0);
        check("addr_valid", addr_valid, 1'b0);
        check("pc", pc, pc_start);
        check("pre_dec", uut.pre_dec, 1'b0);
        check("post_inc", uut.post_inc, 1'b0);
    endtask

    task automatic load_regs();
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_code <= reg_code_t'(r);
            wr_data <= ref_regs[r];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic run_entry(input int i);
        addr_t  exp_addr;
        addr_t  got_addr;
        fetch_t f;
        int     edge_cnt;
        int     lat;
        int     used;
        logic   got;
        win_q.delete();
        for (int b = 0; b < t_len[i]; b++) begin
            win_q.push_back(t_bytes[i][8*b +: 8]);
        end
        expect_addr(i, exp_addr);
        got_addr = '0;
        edge_cnt = 0;
        lat      = 0;
        used     = 0;
        got      = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        op    <= window();
        while (!got) begin
            @(negedge clk);
            f = fetched;
            check("busy", busy, (edge_cnt >= 1) && (edge_cnt < t_lat[i]));
            if (addr_valid) begin
                got      = 1'b1;
                lat      = edge_cnt;
                got_addr = addr;
            end
            @(posedge clk);
            edge_cnt++;
            start <= t_again[i] && (edge_cnt == 1);     // ignored, unit is busy
            for (int b = 0; b < f; b++) begin
                if (win_q.size() > 0) begin
                    void'(win_q.pop_front());
                end
            end
            used += f;
            op <= window();                             // window follows fetched
        end
        check("addr", got_addr, exp_addr);
        check("addr_valid latency", lat, t_lat[i]);
        check("fetched total", used, t_len[i]);
        pc_exp = pc_exp + addr_t'(t_len[i]);
        repeat (t_again[i] ? 4 : 1) begin
            @(negedge clk);
            check("addr_valid", addr_valid, 1'b0);
            check("busy", busy, 1'b0);
        end
        check("pc", pc, pc_exp);
    endtask

    initial begin
        void'($urandom(71));
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        op        = '0;
        wr_en     = 1'b0;
        wr_code   = '0;
        wr_data   = '0;
        errors    = 0;
        checks    = 0;
        cycle_cnt = 0;
        n_entries = 0;
        pc_exp    = pc_start;
        for (int r = 0; r < 8; r++) begin
            ref_regs[r] = $urandom();
        end
        build_table();
        cycle_limit = rst_cycles + 16 + n_entries * 8;
        repeat (rst_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_idle();                                   // still in reset
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle();
        load_regs();
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* idx_addr.f */
design/idx_pkg.sv
design/idx_mode_fsm.sv
design/idx_pc_counter.sv
design/idx_reg_bank.sv
design/idx_addr_calc.sv
design/idx_addr_top.sv
sim/idx_addr_props.sv
sim/idx_addr_tb.sv

/* Bender.yml */
package:
  name: idx_addr

sources:
  - files:
      - design/idx_pkg.sv
      - design/idx_mode_fsm.sv
      - design/idx_pc_counter.sv
      - design/idx_reg_bank.sv
      - design/idx_addr_calc.sv
      - design/idx_addr_top.sv
  - target: simulation
    files:
      - sim/idx_addr_props.sv
      - sim/idx_addr_tb.sv
